//--- boot_stimulus.txt
// header: zero words, image words, corruption index, user op count
// then 32 image words, then one user op per line: op (1 write, 2 read), address, data, expected
00000040
00000020
0000000b
00000007

00000113 00100193 deadbeef 0badf00d
13579bdf 2468ace0 fedcba98 76543210
0f0f0f0f f0f0f0f0 11111111 22222222
33333333 44444444 55555555 66666666
77777777 88888888 99999999 aaaaaaaa
bbbbbbbb cccccccc dddddddd eeeeeeee
01234567 89abcdef a5a5a5a5 5a5a5a5a
80000001 7ffffffe c001d00d 00c0ffee

00000001 fc000200 12345678 12345678
00000002 fc000200 00000000 12345678
00000002 00000000 00000000 00000113
00000002 0400000c 00000000 0badf00d
00000001 00000140 cafef00d cafef00d
00000002 00000140 00000000 cafef00d
00000002 000000c0 00000000 00000000

//--- files.f
mem_map_pkg.sv
boot_pkg.sv
mem_req_if.sv
zero_filler.sv
image_copier.sv
readback_checker.sv
boot_sequencer.sv
boot_top.sv
tb_boot_top.sv

//--- run.sh
#!/bin/sh
# build and run the boot_top regression with Verilator
# exit status is nonzero when the testbench stops with $fatal

cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_boot_top -f files.f -o tb_boot_top &&
./obj_dir/tb_boot_top || exit 1

//--- tb_boot_top.sv
// ------------------------------
// testbench for boot_top
// memory model, image stream and user
// accesses taken from a stimulus file
// ------------------------------

`timescale 1ns/1ps

module tb_boot_top;

    localparam int unsigned zero_words   = 64;
    localparam int unsigned image_words  = 32;
    localparam int unsigned zero_bytes   = zero_words * 4;
    localparam int unsigned image_bytes  = image_words * 4;
    localparam int unsigned mem_words    = 1024;
    localparam int unsigned max_ops      = 16;
    localparam int unsigned stim_words   = 4 + image_words + 4 * max_ops;
    localparam int unsigned reset_cycles = 16;
    localparam logic [31:0] window_mask  = 32'h03ff_ffff;  // low 26 bits
    localparam logic [31:0] seed         = 32'h6e75f04b;

    logic        clk;
    logic        i_rst;
    logic        o_mem_rd_en;
    logic        o_mem_wr_en;
    logic [31:0] o_mem_addr;
    logic [31:0] o_mem_wdata;
    logic [3:0]  o_mem_ctrl;
    logic [31:0] i_mem_rdata;
    logic        i_mem_busy;
    logic [31:0] i_img_data;
    logic        i_img_we;
    logic        o_img_ready;
    logic        i_rd_en;
    logic        i_wr_en;
    logic [31:0] i_addr;
    logic [31:0] i_data;
    logic [3:0]  i_ctrl;
    logic [31:0] o_data;
    logic        o_busy;
    logic        o_init_done;
    logic        o_checksum_match;

    logic [31:0] mem [0:mem_words-1];
    logic [31:0] stim [0:stim_words-1];
    logic [31:0] corrupt_idx;
    logic        corrupt_en;      // second run flips one image word
    int unsigned reset_strobes;   // strobes seen while reset is held
    int unsigned stray_accesses;  // accesses above the zero region before done
    int unsigned init_writes;
    logic [31:0] last_addr;
    logic [3:0]  last_ctrl;       // byte enables of the last accepted access
    int unsigned timeout_cycles;
    int unsigned cycle_count;

    boot_top #(.ZERO_BYTES(zero_bytes), .IMAGE_BYTES(image_bytes)) uut (
        .clk(clk), .i_rst(i_rst),
        .o_mem_rd_en(o_mem_rd_en), .o_mem_wr_en(o_mem_wr_en), .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata), .o_mem_ctrl(o_mem_ctrl),
        .i_mem_rdata(i_mem_rdata), .i_mem_busy(i_mem_busy),
        .i_img_data(i_img_data), .i_img_we(i_img_we), .o_img_ready(o_img_ready),
        .i_rd_en(i_rd_en), .i_wr_en(i_wr_en), .i_addr(i_addr), .i_data(i_data),
        .i_ctrl(i_ctrl), .o_data(o_data), .o_busy(o_busy),
        .o_init_done(o_init_done), .o_checksum_match(o_checksum_match)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // nonzero for every word, differs per address
    function automatic logic [31:0] fill_word(input int unsigned idx);
        return {16'hc0de ^ idx[15:0], idx[15:0]};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // memory controller model, samples on rising edge, drives on falling edge
    initial begin : memory_model
        int unsigned busy_left;
        logic [9:0]  rd_word;
        logic        raise;
        logic        fall;
        logic [31:0] wdata;
        i_mem_busy     = 1'b0;
        i_mem_rdata    = '0;
        reset_strobes  = 0;
        stray_accesses = 0;
        init_writes    = 0;
        last_addr      = '0;
        last_ctrl      = '0;
        busy_left      = 0;
        rd_word        = '0;
        forever begin
            @(posedge clk);
            raise = 1'b0;
            fall  = 1'b0;
            if (i_rst) begin
                if (o_mem_rd_en || o_mem_wr_en)
                    reset_strobes++;
                for (int unsigned i = 0; i < mem_words; i++)
                    mem[i] = fill_word(i);  // preload before every run
                init_writes = 0;
                busy_left   = 0;
                fall        = 1'b1;
            end else if (i_mem_busy) begin
                busy_left--;
                if (busy_left == 0)
                    fall = 1'b1;
            end else if (o_mem_rd_en || o_mem_wr_en) begin
                raise     = 1'b1;
                busy_left = $urandom_range(1, 4);
                last_addr = o_mem_addr;
                last_ctrl = o_mem_ctrl;
                rd_word   = o_mem_addr[11:2];
                if (!o_init_done && o_mem_addr >= zero_bytes)
                    stray_accesses++;
                if (!o_init_done)
                    check_equal("byte enables during init", 32'hf, 32'(o_mem_ctrl));
                if (o_mem_wr_en) begin
                    wdata = o_mem_wdata;
                    if (!o_init_done) begin
                        // zero fill writes come first, image writes follow
                        if (corrupt_en && init_writes == zero_words + corrupt_idx)
                            wdata = ~wdata;
                        init_writes++;
                    end
                    mem[o_mem_addr[11:2]] = wdata;
                end
            end
            @(negedge clk);
            if (raise)
                i_mem_busy = 1'b1;
            if (fall) begin
                i_mem_busy  = 1'b0;
                i_mem_rdata = mem[rd_word];
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        wait (timeout_cycles != 0);
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Regression failed");
        $fatal(1, "timeout after %0d cycles, init or a memory access never finished",
               cycle_count);
    end

    task automatic apply_reset();
        @(negedge clk);
        i_rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        check_equal("init_done in reset", 0, 32'(o_init_done));
        check_equal("busy in reset", 1, 32'(o_busy));
        check_equal("img_ready in reset", 0, 32'(o_img_ready));
        @(negedge clk);
        i_rst = 1'b0;
        check_equal("memory strobes in reset", 0, reset_strobes);
    endtask

    // user strobes above the zero region while init runs
    task automatic drive_early_user_strobes();
        for (int unsigned k = 0; k < 4; k++) begin
            @(negedge clk);
            i_addr  = 32'h0000_0800 + 32'(k * 4);
            i_data  = 32'h5eed_0000 + 32'(k);
            i_ctrl  = 4'hf;
            i_wr_en = 1'b1;
            @(posedge clk);
            check_equal("busy before done", 1, 32'(o_busy));
            @(negedge clk);
            i_wr_en = 1'b0;
            i_rd_en = 1'b1;
            @(posedge clk);
            check_equal("busy before done", 1, 32'(o_busy));
            @(negedge clk);
            i_rd_en = 1'b0;
        end
    endtask

    task automatic send_image();
        for (int unsigned i = 0; i < image_words; i++) begin
            while (!o_img_ready) @(posedge clk);
            repeat ($urandom_range(0, 2)) @(posedge clk);  // ready is a level
            @(negedge clk);
            i_img_data = stim[4 + i];
            i_img_we   = 1'b1;
            @(negedge clk);
            i_img_we   = 1'b0;
        end
    endtask

    task automatic wait_init_done();
        while (!o_init_done) @(posedge clk);
    endtask

    task automatic run_user_op(input int unsigned base);
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] expected;
        logic [31:0] masked;
        logic [3:0]  ctrl;
        op       = stim[base];
        addr     = stim[base + 1];
        expected = stim[base + 3];
        masked   = addr & window_mask;
        ctrl     = (op == 32'd1) ? 4'hf : 4'h3;  // model returns the full word on reads
        @(negedge clk);
        i_addr  = addr;
        i_data  = stim[base + 2];
        i_ctrl  = ctrl;
        i_wr_en = (op == 32'd1);
        i_rd_en = (op != 32'd1);
        @(posedge clk);
        while (!o_busy) @(posedge clk);
        @(negedge clk);
        i_wr_en = 1'b0;
        i_rd_en = 1'b0;
        @(posedge clk);
        while (o_busy) @(posedge clk);
        check_equal($sformatf("byte enables %h", addr), 32'(ctrl), 32'(last_ctrl));
        if (op == 32'd1) begin
            check_equal($sformatf("write address %h", addr), masked, last_addr);
            check_equal($sformatf("write data %h", addr), expected, mem[masked[11:2]]);
        end else begin
            check_equal($sformatf("read data %h", addr), expected, o_data);
        end
    endtask

    initial begin : main_seq
        logic [31:0] exp_sum;
        logic [31:0] exp_read_sum;
        logic [31:0] img_k;
        int unsigned n_ops;
        void'($urandom(seed));
        i_rst      = 1'b1;
        i_img_data = '0;
        i_img_we   = 1'b0;
        i_rd_en    = 1'b0;
        i_wr_en    = 1'b0;
        i_addr     = '0;
        i_data     = '0;
        i_ctrl     = '0;
        corrupt_en = 1'b0;
        $readmemh("boot_stimulus.txt", stim);
        check_equal("zero size in file", zero_words, stim[0]);
        check_equal("image size in file", image_words, stim[1]);
        corrupt_idx    = stim[2];
        n_ops          = stim[3];
        timeout_cycles = 2 * (zero_words + 2 * image_words + n_ops) * 8 + reset_cycles;
        exp_sum = '0;
        for (int unsigned i = 0; i < image_words; i++)
            exp_sum = exp_sum + stim[4 + i];

        // clean run
        apply_reset();
        drive_early_user_strobes();
        send_image();
        wait_init_done();
        check_equal("user accesses before done", 0, stray_accesses);
        for (int unsigned i = 0; i < image_words; i++)
            check_equal($sformatf("image word %0d", i), stim[4 + i], mem[i]);
        for (int unsigned i = image_words; i < zero_words; i++)
            check_equal($sformatf("zero word %0d", i), 32'h0, mem[i]);
        for (int unsigned i = zero_words; i < mem_words; i++)
            check_equal($sformatf("untouched word %0d", i), fill_word(i), mem[i]);
        check_equal("checksum match clean", 1, 32'(o_checksum_match));
        for (int unsigned i = 0; i < n_ops; i++)
            run_user_op(4 + image_words + 4 * i);

        // corrupted run, one image word lands inverted
        corrupt_en = 1'b1;
        apply_reset();
        send_image();
        wait_init_done();
        img_k        = stim[4 + corrupt_idx];
        exp_read_sum = exp_sum - img_k + ~img_k;
        check_equal("corrupted word", ~img_k, mem[corrupt_idx[9:0]]);
        check_equal("checksum match corrupted", 32'(exp_sum == exp_read_sum),
                    32'(o_checksum_match));

        $display("Regression passed");
        $finish;
    end

endmodule

//--- boot_top.sv
// ------------------------------
// memory boot maintenance top
// zero fill, image copy, readback check
// then user pass-through to memory
// ------------------------------

`timescale 1ns/1ps

module boot_top #(
    parameter int unsigned ZERO_BYTES  = mem_map_pkg::default_zero_bytes,
    parameter int unsigned IMAGE_BYTES = mem_map_pkg::default_image_bytes
) (
    input  logic                            clk,
    input  logic                            i_rst,
    // memory controller
    output logic                            o_mem_rd_en,
    output logic                            o_mem_wr_en,
    output logic [mem_map_pkg::addr_w-1:0]  o_mem_addr,
    output logic [boot_pkg::data_w-1:0]     o_mem_wdata,
    output logic [boot_pkg::ctrl_w-1:0]     o_mem_ctrl,
    input  logic [boot_pkg::data_w-1:0]     i_mem_rdata,
    input  logic                            i_mem_busy,
    // boot image stream
    input  logic [boot_pkg::data_w-1:0]     i_img_data,
    input  logic                            i_img_we,
    output logic                            o_img_ready,
    // processor side
    input  logic                            i_rd_en,
    input  logic                            i_wr_en,
    input  logic [mem_map_pkg::addr_w-1:0]  i_addr,
    input  logic [boot_pkg::data_w-1:0]     i_data,
    input  logic [boot_pkg::ctrl_w-1:0]     i_ctrl,
    output logic [boot_pkg::data_w-1:0]     o_data,
    output logic                            o_busy,
    // status
    output logic                            o_init_done,
    output logic                            o_checksum_match
);

    mem_req_if zero_ch ();
    mem_req_if copy_ch ();
    mem_req_if check_ch ();

    logic                        zero_start, copy_start, check_start;
    logic                        zero_done, copy_done, check_done;
    logic [boot_pkg::data_w-1:0] write_sum;
    logic [boot_pkg::data_w-1:0] read_sum;

    zero_filler #(.ZERO_BYTES(ZERO_BYTES)) u_zero (
        .clk(clk), .i_rst(i_rst), .i_start(zero_start), .o_done(zero_done), .mem(zero_ch)
    );

    image_copier #(.IMAGE_BYTES(IMAGE_BYTES)) u_copy (
        .clk(clk), .i_rst(i_rst), .i_start(copy_start),
        .i_img_data(i_img_data), .i_img_we(i_img_we), .o_img_ready(o_img_ready),
        .o_done(copy_done), .o_checksum(write_sum), .mem(copy_ch)
    );

    readback_checker #(.IMAGE_BYTES(IMAGE_BYTES)) u_check (
        .clk(clk), .i_rst(i_rst), .i_start(check_start),
        .o_done(check_done), .o_checksum(read_sum), .mem(check_ch)
    );

    boot_sequencer #(.ZERO_BYTES(ZERO_BYTES), .IMAGE_BYTES(IMAGE_BYTES)) u_seq (
        .clk(clk), .i_rst(i_rst),
        .zero_ch(zero_ch), .copy_ch(copy_ch), .check_ch(check_ch),
        .i_zero_done(zero_done), .i_copy_done(copy_done), .i_check_done(check_done),
        .i_write_sum(write_sum), .i_read_sum(read_sum),
        .o_zero_start(zero_start), .o_copy_start(copy_start), .o_check_start(check_start),
        .i_rd_en(i_rd_en), .i_wr_en(i_wr_en), .i_addr(i_addr), .i_data(i_data),
        .i_ctrl(i_ctrl), .o_data(o_data), .o_busy(o_busy),
        .o_mem_rd_en(o_mem_rd_en), .o_mem_wr_en(o_mem_wr_en), .o_mem_addr(o_mem_addr),
        .o_mem_wdata(o_mem_wdata), .o_mem_ctrl(o_mem_ctrl),
        .i_mem_rdata(i_mem_rdata), .i_mem_busy(i_mem_busy),
        .o_init_done(o_init_done), .o_checksum_match(o_checksum_match)
    );

endmodule

//--- boot_sequencer.sv
// ------------------------------
// boot sequencer
// steps the init states, owns the memory port
// and gates the user path until done
// ------------------------------

`timescale 1ns/1ps

module boot_sequencer #(
    parameter int unsigned ZERO_BYTES  = mem_map_pkg::default_zero_bytes,
    parameter int unsigned IMAGE_BYTES = mem_map_pkg::default_image_bytes
) (
    input  logic                            clk,
    input  logic                            i_rst,
    mem_req_if.slave                        zero_ch,
    mem_req_if.slave                        copy_ch,
    mem_req_if.slave                        check_ch,
    input  logic                            i_zero_done,
    input  logic                            i_copy_done,
    input  logic                            i_check_done,
    input  logic [boot_pkg::data_w-1:0]     i_write_sum,
    input  logic [boot_pkg::data_w-1:0]     i_read_sum,
    output logic                            o_zero_start,
    output logic                            o_copy_start,
    output logic                            o_check_start,
    input  logic                            i_rd_en,
    input  logic                            i_wr_en,
    input  logic [mem_map_pkg::addr_w-1:0]  i_addr,
    input  logic [boot_pkg::data_w-1:0]     i_data,
    input  logic [boot_pkg::ctrl_w-1:0]     i_ctrl,
    output logic [boot_pkg::data_w-1:0]     o_data,
    output logic                            o_busy,
    output logic                            o_mem_rd_en,
    output logic                            o_mem_wr_en,
    output logic [mem_map_pkg::addr_w-1:0]  o_mem_addr,
    output logic [boot_pkg::data_w-1:0]     o_mem_wdata,
    output logic [boot_pkg::ctrl_w-1:0]     o_mem_ctrl,
    input  logic [boot_pkg::data_w-1:0]     i_mem_rdata,
    input  logic                            i_mem_busy,
    output logic                            o_init_done,
    output logic                            o_checksum_match
);

    // empty regions are skipped
    localparam boot_pkg::init_state_t after_zero =
        (IMAGE_BYTES != 0) ? boot_pkg::st_load : boot_pkg::st_done;
    localparam boot_pkg::init_state_t after_reset =
        (ZERO_BYTES != 0) ? boot_pkg::st_zero : after_zero;

    boot_pkg::init_state_t state_q;
    boot_pkg::init_state_t state_d;
    logic                  match_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            boot_pkg::st_reset:  state_d = after_reset;
            boot_pkg::st_zero:   if (i_zero_done) state_d = after_zero;
            boot_pkg::st_load:   if (i_copy_done) state_d = boot_pkg::st_verify;
            boot_pkg::st_verify: if (i_check_done) state_d = boot_pkg::st_done;
            boot_pkg::st_done:   state_d = boot_pkg::st_done;
            default:             state_d = boot_pkg::st_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_q <= boot_pkg::st_reset;
            match_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // both sums are final once the readback ends
            if (state_d == boot_pkg::st_done && state_q != boot_pkg::st_done)
                match_q <= (i_write_sum == i_read_sum);
        end
    end

    // only the active engine reaches memory, the others see busy
    always_comb begin
        o_mem_rd_en   = 1'b0;
        o_mem_wr_en   = 1'b0;
        o_mem_addr    = '0;
        o_mem_wdata   = '0;
        o_mem_ctrl    = boot_pkg::ctrl_all;
        zero_ch.busy  = 1'b1;
        copy_ch.busy  = 1'b1;
        check_ch.busy = 1'b1;
        case (state_q)
            boot_pkg::st_zero: begin
                o_mem_rd_en  = zero_ch.rd_en;
                o_mem_wr_en  = zero_ch.wr_en;
                o_mem_addr   = zero_ch.addr;
                o_mem_wdata  = zero_ch.wdata;
                o_mem_ctrl   = zero_ch.ctrl;  // engines drive all lanes
                zero_ch.busy = i_mem_busy;
            end
            boot_pkg::st_load: begin
                o_mem_rd_en  = copy_ch.rd_en;
                o_mem_wr_en  = copy_ch.wr_en;
                o_mem_addr   = copy_ch.addr;
                o_mem_wdata  = copy_ch.wdata;
                o_mem_ctrl   = copy_ch.ctrl;
                copy_ch.busy = i_mem_busy;
            end
            boot_pkg::st_verify: begin
                o_mem_rd_en   = check_ch.rd_en;
                o_mem_wr_en   = check_ch.wr_en;
                o_mem_addr    = check_ch.addr;
                o_mem_wdata   = check_ch.wdata;
                o_mem_ctrl    = check_ch.ctrl;
                check_ch.busy = i_mem_busy;
            end
            boot_pkg::st_done: begin
                o_mem_rd_en = i_rd_en;
                o_mem_wr_en = i_wr_en;
                o_mem_addr  = i_addr & mem_map_pkg::addr_mask;
                o_mem_wdata = i_data;
                o_mem_ctrl  = i_ctrl;
            end
            default: ;  // st_reset, no requests
        endcase
    end

    assign zero_ch.rdata  = i_mem_rdata;
    assign copy_ch.rdata  = i_mem_rdata;
    assign check_ch.rdata = i_mem_rdata;

    assign o_zero_start     = (state_q == boot_pkg::st_zero);
    assign o_copy_start     = (state_q == boot_pkg::st_load);
    assign o_check_start    = (state_q == boot_pkg::st_verify);
    assign o_init_done      = (state_q == boot_pkg::st_done);
    assign o_busy           = o_init_done ? i_mem_busy : 1'b1;  // user waits during init
    assign o_data           = i_mem_rdata;
    assign o_checksum_match = match_q;

endmodule

//--- readback_checker.sv
// ------------------------------
// readback engine
// reads the image region back and
// sums the returned words
// ------------------------------

`timescale 1ns/1ps

module readback_checker #(
    parameter int unsigned IMAGE_BYTES = mem_map_pkg::default_image_bytes
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_start,
    output logic                         o_done,
    output logic [boot_pkg::data_w-1:0]  o_checksum,
    mem_req_if.master                    mem
);

    logic [mem_map_pkg::addr_w-1:0] addr_q;
    logic [boot_pkg::data_w-1:0]    sum_q;
    logic                           rd_q;
    logic                           pend_q;  // read accepted, data comes when busy falls
    logic                           done_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            addr_q <= '0;
            sum_q  <= '0;
            rd_q   <= 1'b0;
            pend_q <= 1'b0;
            done_q <= 1'b0;
        end else if (i_start && !done_q) begin
            if (!rd_q && !pend_q) begin
                if (addr_q >= IMAGE_BYTES)
                    done_q <= 1'b1;  // past the last image word
                else if (!mem.busy)
                    rd_q <= 1'b1;
            end else if (rd_q) begin
                if (mem.busy) begin
                    rd_q   <= 1'b0;
                    pend_q <= 1'b1;
                end
            end else if (!mem.busy) begin
                // rdata valid in this cycle
                pend_q <= 1'b0;
                sum_q  <= sum_q + mem.rdata;
                addr_q <= addr_q + mem_map_pkg::word_bytes;
            end
        end
    end

    assign mem.rd_en  = rd_q;
    assign mem.wr_en  = 1'b0;
    assign mem.addr   = addr_q;
    assign mem.wdata  = '0;
    assign mem.ctrl   = boot_pkg::ctrl_all;
    assign o_done     = done_q;
    assign o_checksum = sum_q;

endmodule

//--- image_copier.sv
// ------------------------------
// image copy engine
// writes stream words from address 0 up
// and sums them as they complete
// ------------------------------

`timescale 1ns/1ps

module image_copier #(
    parameter int unsigned IMAGE_BYTES = mem_map_pkg::default_image_bytes
) (
    input  logic                         clk,
    input  logic                         i_rst,
    input  logic                         i_start,
    input  logic [boot_pkg::data_w-1:0]  i_img_data,
    input  logic                         i_img_we,
    output logic                         o_img_ready,
    output logic                         o_done,
    output logic [boot_pkg::data_w-1:0]  o_checksum,
    mem_req_if.master                    mem
);

    logic [mem_map_pkg::addr_w-1:0] addr_q;
    logic [mem_map_pkg::addr_w-1:0] addr_next;
    logic [boot_pkg::data_w-1:0]    data_q;  // captured stream word
    logic [boot_pkg::data_w-1:0]    sum_q;
    logic                           ready_q;
    logic                           full_q;  // word held, not yet written
    logic                           wr_q;
    logic                           pend_q;
    logic                           done_q;

    assign addr_next = addr_q + mem_map_pkg::word_bytes;

    always_ff @(posedge clk) begin
        if (i_start && !full_q && ready_q && i_img_we)
            data_q <= i_img_data;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            addr_q  <= '0;
            sum_q   <= '0;
            ready_q <= 1'b0;
            full_q  <= 1'b0;
            wr_q    <= 1'b0;
            pend_q  <= 1'b0;
            done_q  <= 1'b0;
        end else if (i_start && !done_q) begin
            if (!full_q) begin
                if (ready_q && i_img_we) begin
                    full_q  <= 1'b1;
                    ready_q <= 1'b0;
                end else begin
                    ready_q <= 1'b1;  // first cycle after start
                end
            end else if (!wr_q && !pend_q) begin
                if (!mem.busy)
                    wr_q <= 1'b1;
            end else if (wr_q) begin
                if (mem.busy) begin
                    wr_q   <= 1'b0;
                    pend_q <= 1'b1;
                end
            end else if (!mem.busy) begin
                // write complete, advance and accumulate
                pend_q <= 1'b0;
                full_q <= 1'b0;
                addr_q <= addr_next;
                sum_q  <= sum_q + data_q;
                if (addr_next >= IMAGE_BYTES)
                    done_q <= 1'b1;
                else
                    ready_q <= 1'b1;
            end
        end
    end

    assign mem.rd_en   = 1'b0;
    assign mem.wr_en   = wr_q;
    assign mem.addr    = addr_q;
    assign mem.wdata   = data_q;
    assign mem.ctrl    = boot_pkg::ctrl_all;
    assign o_img_ready = ready_q;
    assign o_done      = done_q;
    assign o_checksum  = sum_q;

endmodule

//--- zero_filler.sv
// ------------------------------
// zero fill engine
// writes zero words over the low region
// ------------------------------

`timescale 1ns/1ps

module zero_filler #(
    parameter int unsigned ZERO_BYTES = mem_map_pkg::default_zero_bytes
) (
    input  logic       clk,
    input  logic       i_rst,
    input  logic       i_start,
    output logic       o_done,
    mem_req_if.master  mem
);

    logic [mem_map_pkg::addr_w-1:0] addr_q;
    logic                           wr_q;    // strobe held until busy seen
    logic                           pend_q;  // write accepted, waiting for busy to fall
    logic                           done_q;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            addr_q <= '0;
            wr_q   <= 1'b0;
            pend_q <= 1'b0;
            done_q <= 1'b0;
        end else if (i_start && !done_q) begin
            if (!wr_q && !pend_q) begin
                if (addr_q >= ZERO_BYTES)
                    done_q <= 1'b1;
                else if (!mem.busy)
                    wr_q <= 1'b1;
            end else if (wr_q) begin
                if (mem.busy) begin
                    wr_q   <= 1'b0;
                    pend_q <= 1'b1;
                end
            end else if (!mem.busy) begin  // write complete
                pend_q <= 1'b0;
                addr_q <= addr_q + mem_map_pkg::word_bytes;
            end
        end
    end

    assign mem.rd_en = 1'b0;
    assign mem.wr_en = wr_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
    assign mem.ctrl  = boot_pkg::ctrl_all;
    assign o_done    = done_q;

endmodule

//--- mem_req_if.sv
// ------------------------------
// memory request channel
// one requester to the sequencer port mux
// ------------------------------

`timescale 1ns/1ps

interface mem_req_if;

    logic                            rd_en;
    logic                            wr_en;
    logic [mem_map_pkg::addr_w-1:0]  addr;
    logic [boot_pkg::data_w-1:0]     wdata;
    logic [boot_pkg::ctrl_w-1:0]     ctrl;
    logic [boot_pkg::data_w-1:0]     rdata;  // valid when busy falls after a read
    logic                            busy;   // held high on idle channels

    // engine side
    modport master (
        output rd_en, wr_en, addr, wdata, ctrl,
        input  rdata, busy
    );

    // sequencer side
    modport slave (
        input  rd_en, wr_en, addr, wdata, ctrl,
        output rdata, busy
    );

endinterface

//--- boot_pkg.sv
// ------------------------------
// boot control definitions
// bus widths and init sequence states
// ------------------------------

package boot_pkg;

    // data word on the memory bus
    localparam int unsigned data_w = 32;

    // one enable bit per byte lane
    localparam int unsigned ctrl_w = 4;

    // full word access, used by every init engine
    localparam logic [ctrl_w-1:0] ctrl_all = 4'b1111;

    // init sequence, stepped by the boot sequencer
    typedef enum logic [2:0] {
        st_reset  = 3'd0,  // waiting one cycle after reset
        st_zero   = 3'd1,  // clearing the low region
        st_load   = 3'd2,  // copying the image stream
        st_verify = 3'd3,  // reading the image back
        st_done   = 3'd4   // user pass-through
    } init_state_t;

endpackage

//--- mem_map_pkg.sv
// ------------------------------
// memory map constants
// word size, address window and
// default init region sizes
// ------------------------------

package mem_map_pkg;

    // byte address width on the memory bus
    localparam int unsigned addr_w = 32;

    // one 32-bit word per access
    localparam int unsigned word_bytes = 4;

    // user addresses fold into a 64 MiB window
    localparam logic [addr_w-1:0] addr_mask = 32'h03ff_ffff;

    // low region cleared after reset, in bytes
    localparam int unsigned default_zero_bytes = 256;

    // boot image size in bytes, must fit inside the zero region
    localparam int unsigned default_image_bytes = 128;

endpackage
